// File: compile.f
src/csr_mon_pkg.sv
src/chan_traffic_counter.sv
src/hot_pfn_buffer.sv
src/csr_reg_bank.sv
src/csr_access_fsm.sv
src/csr_mon_top.sv
tb/tb_clk_gen.sv
tb/tb_csr_mon.sv

// File: tb/tb_csr_mon.sv
// ==========================================================================
// memory-monitor CSR block testbench
// directed tests over the Avalon-MM slave port: ID and reset values,
// config readback, traffic counters, hot-PFN capture, index reset and
// unmapped reads, each checked against a model of the register map
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module tb_csr_mon
    import csr_mon_pkg::*;
;

    localparam int NUM_CHAN    = 2;
    localparam int TIMEOUT_CYC = 50;
    // expected constants of the register map
    localparam logic [63:0] EXP_ID    = 64'hABCD_ABCD_ABCD_ABCD;
    localparam logic [15:0] EXP_TAG   = 16'h7469;
    localparam logic [31:0] EXP_UM_HI = 32'hFEDC_BA00;
    localparam logic [15:0] EXP_UM_LO = 16'hABCD;
    localparam int          WIN_BASE  = 4096;

    logic                clk;
    logic                reset_n;
    logic                bus_read;
    logic                bus_write;
    logic [31:0]         address;
    logic [63:0]         writedata;
    logic [7:0]          byteenable;
    logic [63:0]         readdata;
    logic                readdatavalid;
    logic                waitrequest;
    logic [NUM_CHAN-1:0] chan_rd;
    logic [NUM_CHAN-1:0] chan_wr;
    logic                mig_en;
    logic [27:0]         mig_pfn;
    csr_cfg_t            cfg;

    integer seed;
    int     test_errs;
    int     tests_passed;
    int     tests_failed;
    int     last_latency;

    tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) i_clk_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    csr_mon_top #(.NUM_CHAN(NUM_CHAN), .REGFILE_SIZE(64), .PFN_DEPTH(1024)) i_dut (
        .clk                (clk),
        .reset_n            (reset_n),
        .read_i             (bus_read),
        .write_i            (bus_write),
        .address_i          (address),
        .writedata_i        (writedata),
        .byteenable_i       (byteenable),
        .readdata_o         (readdata),
        .readdatavalid_o    (readdatavalid),
        .waitrequest_o      (waitrequest),
        .chan_rd_i          (chan_rd),
        .chan_wr_i          (chan_wr),
        .page_mig_addr_en_i (mig_en),
        .page_mig_addr_i    (mig_pfn),
        .cfg_o              (cfg)
    );

    // ======================================================================
    // models and reporting
    // ======================================================================

    // bytes with their enable low read and write as zero
    function automatic logic [63:0] keep_enabled_bytes(input logic [63:0] d,
                                                       input logic [7:0] be);
        logic [63:0] r;
        r = d;
        for (int b = 0; b < 8; b++) begin
            if (!be[b]) begin
                r[b*8 +: 8] = 8'h00;
            end
        end
        return r;
    endfunction

    // page number to byte address, add offset, wrap at 2^34, rebase on start_pa
    function automatic logic [31:0] convert_pfn(input logic [27:0] pfn,
                                                input logic [63:0] start_pa,
                                                input logic [63:0] offset);
        logic [63:0] ba;
        logic [63:0] page;
        ba   = ({36'h0, pfn} << 12) + offset;
        ba   = ba % 64'h4_0000_0000;
        page = (ba >> 12) + (start_pa >> 12);
        return page[31:0];
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        test_errs++;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // ======================================================================
    // bus tasks
    // ======================================================================

    // request held until waitrequest drops, then released on the next edge
    task automatic csr_write(input logic [31:0] addr, input logic [63:0] data,
                             input logic [7:0] be);
        int waited;
        waited = 0;
        @(posedge clk);
        bus_write  <= 1'b1;
        address    <= addr;
        writedata  <= data;
        byteenable <= be;
        do begin
            @(negedge clk);
            waited++;
        end while (waitrequest && waited < TIMEOUT_CYC);
        if (waitrequest) begin
            abort_on_timeout("waitrequest stayed high during a write");
        end
        @(posedge clk);
        bus_write <= 1'b0;
    endtask

    // latency counted from the edge that samples the request
    task automatic csr_read(input logic [31:0] addr, input logic [7:0] be,
                            output logic [63:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        bus_read   <= 1'b1;
        address    <= addr;
        byteenable <= be;
        do begin
            @(negedge clk);
            waited++;
        end while (!readdatavalid && waited < TIMEOUT_CYC);
        if (!readdatavalid) begin
            abort_on_timeout("readdatavalid never rose during a read");
        end
        data         = readdata;
        last_latency = waited - 1;
        @(posedge clk);
        bus_read <= 1'b0;
    endtask

    // ======================================================================
    // tests
    // ======================================================================

    task automatic test_reset_id();
        logic [63:0] data;
        @(negedge clk);
        if (readdatavalid !== 1'b0) report_mismatch("readdatavalid", readdatavalid, 0);
        if (waitrequest !== 1'b1) report_mismatch("waitrequest", waitrequest, 1);
        if (readdata !== 64'h0) report_mismatch("readdata", readdata, 0);
        csr_read(32'h0, 8'hFF, data);
        if (data !== EXP_ID) report_mismatch("readdata (word 0)", data, EXP_ID);
        if (last_latency != 3) report_mismatch("register read latency", last_latency, 3);
        // single byte lane
        csr_read(32'h0, 8'h01, data);
        if (data !== 64'hCD) report_mismatch("readdata (word 0, be 01)", data, 64'hCD);
        csr_read(5 * 8, 8'hFF, data);
        if (data !== 64'h0) report_mismatch("readdata (word 5)", data, 0);
        finish_test("reset_id");
    endtask

    task automatic test_config();
        int          widx [6];
        logic [63:0] wdata [6];
        logic [7:0]  wbe [6];
        logic [63:0] exp_words [6];
        logic [63:0] data;
        widx  = '{8, 10, 13, 14, 15, 16};
        wdata = '{64'h1122_3344_5566_7788, 64'h0000_0001_2345_6000,
                  64'hFFFF_FF2A_FFFF_FF15, 64'hDEAD_BEEF_0000_3000,
                  64'hFFFF_FFFF_FFFF_FFFF, 64'h0000_0001_8000_0000};
        wbe   = '{8'hFF, 8'hFF, 8'h11, 8'h0F, 8'h1F, 8'hFF};
        for (int k = 0; k < 6; k++) begin
            exp_words[k] = keep_enabled_bytes(wdata[k], wbe[k]);
            csr_write(widx[k] * 8, wdata[k], wbe[k]);
        end
        for (int k = 0; k < 6; k++) begin
            csr_read(widx[k] * 8, 8'hFF, data);
            if (data !== exp_words[k]) begin
                report_mismatch($sformatf("readdata (word %0d)", widx[k]), data, exp_words[k]);
            end
        end
        @(negedge clk);
        // decoded fields at the top port
        if (cfg.query_rate !== exp_words[0][31:0])
            report_mismatch("cfg_o.query_rate", cfg.query_rate, exp_words[0][31:0]);
        if (cfg.start_pa !== exp_words[1])
            report_mismatch("cfg_o.start_pa", cfg.start_pa, exp_words[1]);
        if (cfg.aruser !== exp_words[2][5:0])
            report_mismatch("cfg_o.aruser", cfg.aruser, exp_words[2][5:0]);
        if (cfg.awuser !== exp_words[2][37:32])
            report_mismatch("cfg_o.awuser", cfg.awuser, exp_words[2][37:32]);
        if (cfg.addr_offset !== exp_words[3])
            report_mismatch("cfg_o.addr_offset", cfg.addr_offset, exp_words[3]);
        if (cfg.addr_lb !== exp_words[4][32:0])
            report_mismatch("cfg_o.addr_lb", cfg.addr_lb, exp_words[4][32:0]);
        if (cfg.addr_ub !== exp_words[5][32:0])
            report_mismatch("cfg_o.addr_ub", cfg.addr_ub, exp_words[5][32:0]);
        // status words ignore writes
        csr_write(32'h0, 64'h1234_5678_9ABC_DEF0, 8'hFF);
        csr_read(32'h0, 8'hFF, data);
        if (data !== EXP_ID) report_mismatch("readdata (word 0 after write)", data, EXP_ID);
        finish_test("config");
    endtask

    task automatic test_traffic();
        logic [31:0] rnd;
        logic [63:0] rd_tally;
        logic [63:0] wr_tally;
        logic [63:0] data;
        rd_tally = '0;
        wr_tally = '0;
        repeat (200) begin
            @(posedge clk);
            rnd = $random(seed);
            chan_rd <= rnd[NUM_CHAN-1:0];
            chan_wr <= rnd[NUM_CHAN+3:4];
            rd_tally = rd_tally + $countones(rnd[NUM_CHAN-1:0]);
            wr_tally = wr_tally + $countones(rnd[NUM_CHAN+3:4]);
        end
        @(posedge clk);
        chan_rd <= '0;
        chan_wr <= '0;
        // let the sums settle into the status words
        repeat (4) @(posedge clk);
        csr_read(1 * 8, 8'hFF, data);
        if (data !== rd_tally) report_mismatch("readdata (word 1)", data, rd_tally);
        csr_read(2 * 8, 8'hFF, data);
        if (data !== wr_tally) report_mismatch("readdata (word 2)", data, wr_tally);
        finish_test("traffic");
    endtask

    task automatic test_hot_pfn();
        logic [63:0] start_pa;
        logic [63:0] offset;
        logic [27:0] pfns [5];
        logic [31:0] stored [$];
        logic [63:0] data;
        logic [63:0] exp;
        logic [31:0] addr;
        start_pa = 64'h0000_0004_0000_0000;
        // large offset so some addresses wrap past 2^34
        offset   = 64'h0000_0003_FFFF_F000;
        pfns     = '{28'h000_0123, 28'hFFF_FFFF, 28'h0AB_CDEF, 28'h000_0001, 28'h7FF_FFFF};
        csr_write(10 * 8, start_pa, 8'hFF);
        csr_write(14 * 8, offset, 8'hFF);
        foreach (pfns[k]) begin
            @(posedge clk);
            mig_en  <= 1'b1;
            mig_pfn <= pfns[k];
            if (pfns[k] != 28'hFFF_FFFF) begin
                stored.push_back(convert_pfn(pfns[k], start_pa, offset));
            end
        end
        @(posedge clk);
        mig_en  <= 1'b0;
        mig_pfn <= '0;
        repeat (3) @(posedge clk);
        // every pulse counts, the all-ones page too
        csr_read(3 * 8, 8'hFF, data);
        exp = $size(pfns);
        if (data !== exp) report_mismatch("readdata (word 3)", data, exp);
        // first capture since reset so the ring starts at slot 0 with no wraps
        csr_read(4 * 8, 8'hFF, data);
        exp = {16'h0, 6'h0, 10'(stored.size()), 32'h0};
        if (data !== exp) report_mismatch("readdata (word 4)", data, exp);
        // window entries: tag, address low bits, converted page
        foreach (stored[k]) begin
            addr = (WIN_BASE + k) * 8;
            csr_read(addr, 8'hFF, data);
            exp = {EXP_TAG, addr[15:0], stored[k]};
            if (data !== exp) report_mismatch($sformatf("readdata (pfn %0d)", k), data, exp);
            if (last_latency != 4) report_mismatch("window read latency", last_latency, 4);
        end
        finish_test("hot_pfn");
    endtask

    task automatic test_idx_rst_unmapped();
        logic [63:0] data;
        logic [63:0] exp;
        logic [31:0] addr;
        csr_write(11 * 8, 64'h0000_0000_0000_0100, 8'h02);
        repeat (2) @(posedge clk);
        csr_read(4 * 8, 8'hFF, data);
        if (data[41:32] !== 10'h0) report_mismatch("wr_idx (word 4)", data[41:32], 0);
        addr = 100 * 8;
        csr_read(addr, 8'hFF, data);
        exp = {EXP_UM_HI, addr[15:0], EXP_UM_LO};
        if (data !== exp) report_mismatch("readdata (word 100)", data, exp);
        if (last_latency != 3) report_mismatch("unmapped read latency", last_latency, 3);
        // past the end of the window
        addr = 9000 * 8;
        csr_read(addr, 8'hFF, data);
        exp = {EXP_UM_HI, addr[15:0], EXP_UM_LO};
        if (data !== exp) report_mismatch("readdata (word 9000)", data, exp);
        finish_test("idx_rst_unmapped");
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        int waited;
        seed         = 32'h24c0_1700;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        last_latency = 0;
        bus_read     = 1'b0;
        bus_write    = 1'b0;
        address      = '0;
        writedata    = '0;
        byteenable   = '0;
        chan_rd      = '0;
        chan_wr      = '0;
        mig_en       = 1'b0;
        mig_pfn      = '0;
        waited       = 0;
        while (reset_n !== 1'b1 && waited < TIMEOUT_CYC) begin
            @(negedge clk);
            waited++;
        end
        if (reset_n !== 1'b1) begin
            abort_on_timeout("reset_n was never released");
        end
        test_reset_id();
        test_config();
        test_traffic();
        test_hot_pfn();
        test_idx_rst_unmapped();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
// ==========================================================================
// testbench clock and reset generator
// free-running clock, reset_n held low for the first few rising edges
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
)(
    output logic clk_o,
    output logic reset_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // synchronous reset, released on a rising edge
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: src/csr_mon_top.sv
// ==========================================================================
// memory-monitor CSR block, top level
// Avalon-MM slave with channel traffic counters, register bank, hot-PFN
// ring buffer and the access FSM
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module csr_mon_top
    import csr_mon_pkg::*;
#(
    parameter int NUM_CHAN     = 2,
    parameter int REGFILE_SIZE = 64,
    parameter int PFN_DEPTH    = 1024
)(
    input  wire                 clk,
    input  wire                 reset_n,
    // slave port
    input  wire                 read_i,
    input  wire                 write_i,
    input  wire [ADDR_W-1:0]    address_i,
    input  wire [DATA_W-1:0]    writedata_i,
    input  wire [BE_W-1:0]      byteenable_i,
    output logic [DATA_W-1:0]   readdata_o,
    output logic                readdatavalid_o,
    output logic                waitrequest_o,
    // memory channel traffic, one bit per channel
    input  wire [NUM_CHAN-1:0]  chan_rd_i,
    input  wire [NUM_CHAN-1:0]  chan_wr_i,
    // page migration tracker
    input  wire                 page_mig_addr_en_i,
    input  wire [PFN_W-1:0]     page_mig_addr_i,
    output csr_cfg_t            cfg_o
);

    csr_req_t          req;
    chan_count_t       chan_counts [NUM_CHAN];
    pfn_status_t       pfn_status;
    logic              reg_wr_en;
    logic [WIDX_W-1:0] word_idx;
    logic [DATA_W-1:0] reg_rdata;
    logic              pfn_rd_en;
    logic [WIDX_W-1:0] pfn_idx;
    logic [31:0]       pfn_rdata;
    logic              pfn_idx_rst;

    assign req.read       = read_i;
    assign req.write      = write_i;
    assign req.address    = address_i;
    assign req.writedata  = writedata_i;
    assign req.byteenable = byteenable_i;

    // one counter per memory channel
    for (genvar g = 0; g < NUM_CHAN; g++) begin : g_chan
        chan_traffic_counter i_cnt (
            .clk        (clk),
            .reset_n    (reset_n),
            .rd_pulse_i (chan_rd_i[g]),
            .wr_pulse_i (chan_wr_i[g]),
            .count_o    (chan_counts[g])
        );
    end

    csr_reg_bank #(.NUM_CHAN(NUM_CHAN), .REGFILE_SIZE(REGFILE_SIZE)) i_bank (
        .clk           (clk),
        .reset_n       (reset_n),
        .wr_en_i       (reg_wr_en),
        .wr_idx_i      (word_idx),
        .wr_data_i     (req.writedata),
        .wr_be_i       (req.byteenable),
        .rd_idx_i      (word_idx),
        .rd_data_o     (reg_rdata),
        .counts_i      (chan_counts),
        .mig_en_i      (page_mig_addr_en_i),
        .pfn_status_i  (pfn_status),
        .pfn_idx_rst_o (pfn_idx_rst),
        .cfg_o         (cfg_o)
    );

    hot_pfn_buffer #(.PFN_DEPTH(PFN_DEPTH)) i_pfn_buf (
        .clk           (clk),
        .reset_n       (reset_n),
        .mig_en_i      (page_mig_addr_en_i),
        .mig_pfn_i     (page_mig_addr_i),
        .start_pa_i    (cfg_o.start_pa),
        .addr_offset_i (cfg_o.addr_offset),
        .idx_rst_i     (pfn_idx_rst),
        .rd_en_i       (pfn_rd_en),
        .rd_idx_i      (pfn_idx),
        .rd_pfn_o      (pfn_rdata),
        .status_o      (pfn_status)
    );

    csr_access_fsm #(.REGFILE_SIZE(REGFILE_SIZE)) i_fsm (
        .clk             (clk),
        .reset_n         (reset_n),
        .req_i           (req),
        .reg_rdata_i     (reg_rdata),
        .pfn_rdata_i     (pfn_rdata),
        .reg_wr_en_o     (reg_wr_en),
        .word_idx_o      (word_idx),
        .pfn_rd_en_o     (pfn_rd_en),
        .pfn_idx_o       (pfn_idx),
        .readdata_o      (readdata_o),
        .readdatavalid_o (readdatavalid_o),
        .waitrequest_o   (waitrequest_o)
    );

endmodule

`default_nettype wire

// File: src/csr_access_fsm.sv
// ==========================================================================
// CSR slave-port access FSM
// classifies each request as register, PFN window or unmapped, drives
// waitrequest and readdatavalid, and registers the read data
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module csr_access_fsm
    import csr_mon_pkg::*;
#(
    parameter int REGFILE_SIZE = 64
)(
    input  wire               clk,
    input  wire               reset_n,
    input  csr_req_t          req_i,
    input  wire [DATA_W-1:0]  reg_rdata_i,
    input  wire [31:0]        pfn_rdata_i,
    output logic              reg_wr_en_o,
    output logic [WIDX_W-1:0] word_idx_o,
    output logic              pfn_rd_en_o,
    output logic [WIDX_W-1:0] pfn_idx_o,
    output logic [DATA_W-1:0] readdata_o,
    output logic              readdatavalid_o,
    output logic              waitrequest_o
);

    csr_state_e        state_q;
    csr_state_e        state_d;
    rd_src_e           src_cls;
    rd_src_e           src_q;
    logic              hold_q;
    logic [DATA_W-1:0] rd_mask;

    assign word_idx_o = req_i.address[21:3];
    assign pfn_idx_o  = word_idx_o - WIDX_W'(PFN_WIN_BASE);
    assign rd_mask    = byte_mask(req_i.byteenable);

    // address class
    always_comb begin
        if (word_idx_o < REGFILE_SIZE) begin
            src_cls = SRC_REG;
        end else if (word_idx_o >= PFN_WIN_BASE && word_idx_o < PFN_WIN_END) begin
            src_cls = SRC_PFN;
        end else begin
            src_cls = SRC_UNMAPPED;
        end
    end

    // strobes only in IDLE, the request stays up until waitrequest drops
    assign reg_wr_en_o = (state_q == IDLE) && req_i.write && (src_cls == SRC_REG);
    assign pfn_rd_en_o = (state_q == IDLE) && req_i.read && (src_cls == SRC_PFN);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i.write) begin
                    state_d = WRITE;
                end else if (req_i.read) begin
                    state_d = READ_WAIT;
                end
            end
            WRITE:      state_d = IDLE;
            // window reads spend one extra cycle here for the ring read
            READ_WAIT:  state_d = hold_q ? READ_WAIT : READ_WAIT2;
            READ_WAIT2: state_d = READ;
            READ:       state_d = IDLE;
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q    <= IDLE;
            src_q      <= SRC_REG;
            hold_q     <= 1'b0;
            readdata_o <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && req_i.read) begin
                src_q  <= src_cls;
                hold_q <= (src_cls == SRC_PFN);
            end else if (state_q == READ_WAIT) begin
                hold_q <= 1'b0;
            end
            // load read data on the way into READ
            if (state_q == READ_WAIT2) begin
                case (src_q)
                    SRC_REG: readdata_o <= reg_rdata_i & rd_mask;
                    SRC_PFN: readdata_o <= {PFN_TAG, req_i.address[15:0], pfn_rdata_i};
                    default: readdata_o <= {UNMAPPED_HI, req_i.address[15:0], UNMAPPED_LO};
                endcase
            end
        end
    end

    assign waitrequest_o   = !(state_q == WRITE || state_q == READ);
    assign readdatavalid_o = (state_q == READ);

    // read data is built from the live request so the master holds it while waiting
    a_rd_req_held: assert property (@(posedge clk) disable iff (!reset_n)
        (state_q == READ_WAIT || state_q == READ_WAIT2) |->
            req_i.read && $stable(req_i.address) && $stable(req_i.byteenable));

endmodule

`default_nettype wire

// File: src/csr_reg_bank.sv
// ==========================================================================
// CSR register bank
// words 0-7 are status refreshed every cycle, the rest are read/write
// with byte-enable masking; sums channel traffic, counts migrations and
// decodes the configuration words
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module csr_reg_bank
    import csr_mon_pkg::*;
#(
    parameter int NUM_CHAN     = 2,
    parameter int REGFILE_SIZE = 64
)(
    input  wire               clk,
    input  wire               reset_n,
    input  wire               wr_en_i,
    input  wire [WIDX_W-1:0]  wr_idx_i,
    input  wire [DATA_W-1:0]  wr_data_i,
    input  wire [BE_W-1:0]    wr_be_i,
    input  wire [WIDX_W-1:0]  rd_idx_i,
    output logic [DATA_W-1:0] rd_data_o,
    input  chan_count_t       counts_i [NUM_CHAN],
    input  wire               mig_en_i,
    input  pfn_status_t       pfn_status_i,
    output logic              pfn_idx_rst_o,
    output csr_cfg_t          cfg_o
);

    localparam int RIDX_W = $clog2(REGFILE_SIZE);

    logic [DATA_W-1:0] regs [REGFILE_SIZE];
    logic [DATA_W-1:0] wr_mask;
    logic [DATA_W-1:0] rd_sum;
    logic [DATA_W-1:0] wr_sum;
    logic [DATA_W-1:0] mig_cnt_q;

    assign wr_mask = byte_mask(wr_be_i);

    // total traffic over all channels
    always_comb begin
        rd_sum = '0;
        wr_sum = '0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            rd_sum = rd_sum + DATA_W'(counts_i[c].rd_cnt);
            wr_sum = wr_sum + DATA_W'(counts_i[c].wr_cnt);
        end
    end

    // ======================================================================
    // register file
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < REGFILE_SIZE; i++) begin
                regs[i] <= '0;
            end
            mig_cnt_q <= '0;
        end else begin
            // every sampled migration counts, valid page or not
            if (mig_en_i) begin
                mig_cnt_q <= mig_cnt_q + 1'b1;
            end
            // writes below RW_BASE are dropped
            if (wr_en_i && (wr_idx_i >= RW_BASE)) begin
                regs[wr_idx_i[RIDX_W-1:0]] <= wr_data_i & wr_mask;
            end
            // status words, one cycle behind their sources
            regs[REG_ID]         <= ID_VALUE;
            regs[REG_RD_TOTAL]   <= rd_sum;
            regs[REG_WR_TOTAL]   <= wr_sum;
            regs[REG_MIG_CNT]    <= mig_cnt_q;
            regs[REG_PFN_STATUS] <= {pfn_status_i.overflow_cnt, 6'h0,
                                     pfn_status_i.wr_idx, 32'h0};
            for (int i = REG_PFN_STATUS + 1; i < RW_BASE; i++) begin
                regs[i] <= '0;
            end
        end
    end

    assign rd_data_o = regs[rd_idx_i[RIDX_W-1:0]];

    // index reset fires on any nonzero masked write, nothing is kept
    assign pfn_idx_rst_o = wr_en_i && (wr_idx_i == REG_PFN_IDX_RST) &&
                           ((wr_data_i & wr_mask) != '0);

    // ======================================================================
    // config decode
    // ======================================================================
    assign cfg_o.query_rate  = regs[REG_QUERY_RATE][31:0];
    assign cfg_o.start_pa    = regs[REG_START_PA];
    // ar/aw user bits share one word
    assign cfg_o.aruser      = regs[REG_AXUSER][5:0];
    assign cfg_o.awuser      = regs[REG_AXUSER][37:32];
    assign cfg_o.addr_offset = regs[REG_ADDR_OFFSET];
    assign cfg_o.addr_lb     = regs[REG_ADDR_LB][32:0];
    assign cfg_o.addr_ub     = regs[REG_ADDR_UB][32:0];

    // FSM only strobes register-class writes
    a_wr_idx_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        wr_en_i |-> (wr_idx_i < REGFILE_SIZE));

endmodule

`default_nettype wire

// File: src/hot_pfn_buffer.sv
// ==========================================================================
// hot-PFN capture buffer
// turns each migrated page number into a physical page number using the
// programmed offset and start address, and keeps it in a ring buffer
// the write index can be cleared and every wrap bumps an overflow count
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module hot_pfn_buffer
    import csr_mon_pkg::*;
#(
    parameter int PFN_DEPTH = 1024
)(
    input  wire               clk,
    input  wire               reset_n,
    input  wire               mig_en_i,
    input  wire [PFN_W-1:0]   mig_pfn_i,
    input  wire [DATA_W-1:0]  start_pa_i,
    input  wire [DATA_W-1:0]  addr_offset_i,
    input  wire               idx_rst_i,
    input  wire               rd_en_i,
    input  wire [WIDX_W-1:0]  rd_idx_i,
    output logic [31:0]       rd_pfn_o,
    output pfn_status_t       status_o
);

    localparam int IDX_W = $clog2(PFN_DEPTH);

    logic [31:0]       pfn_mem [PFN_DEPTH];
    logic [IDX_W-1:0]  wr_idx_q;
    logic [15:0]       overflow_cnt_q;
    logic              mig_valid;
    logic [DATA_W-1:0] byte_addr_full;
    logic [33:0]       byte_addr;
    logic [31:0]       pfn_cvt;

    // an all-ones page number marks an empty slot from the tracker
    assign mig_valid = mig_en_i && (mig_pfn_i != '1);

    // page to byte address plus offset, wrapped to a 16 GB window
    assign byte_addr_full = {24'h0, mig_pfn_i, 12'h0} + addr_offset_i;
    assign byte_addr      = byte_addr_full[33:0];
    // back to a page number relative to the device start page
    assign pfn_cvt = {10'h0, byte_addr[33:12]} + start_pa_i[43:12];

    always_ff @(posedge clk) begin
        if (mig_valid) begin
            pfn_mem[wr_idx_q] <= pfn_cvt;
        end
        // read port, one cycle behind rd_en
        if (rd_en_i) begin
            rd_pfn_o <= pfn_mem[rd_idx_i[IDX_W-1:0]];
        end
    end

    // write index and wrap counter
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_idx_q       <= '0;
            overflow_cnt_q <= '0;
        end else if (idx_rst_i) begin
            wr_idx_q <= '0;
        end else if (mig_valid) begin
            wr_idx_q <= wr_idx_q + 1'b1;
            if (wr_idx_q == '1) begin
                overflow_cnt_q <= overflow_cnt_q + 1'b1;
            end
        end
    end

    assign status_o.wr_idx       = 10'(wr_idx_q);
    assign status_o.overflow_cnt = overflow_cnt_q;

    // window index comes from the access FSM, must land inside the ring
    a_rd_idx_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        rd_en_i |-> (rd_idx_i < PFN_DEPTH));

endmodule

`default_nettype wire

// File: src/chan_traffic_counter.sv
// ==========================================================================
// channel traffic counter
// counts read and write pulses of one memory channel, wrapping at 2^32
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module chan_traffic_counter
    import csr_mon_pkg::*;
(
    input  wire         clk,
    input  wire         reset_n,
    input  wire         rd_pulse_i,
    input  wire         wr_pulse_i,
    output chan_count_t count_o
);

    chan_count_t count_q;

    // a pulse sampled at an edge is counted at that same edge
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            count_q <= '0;
        end else begin
            if (rd_pulse_i) begin
                count_q.rd_cnt <= count_q.rd_cnt + 1'b1;
            end
            if (wr_pulse_i) begin
                count_q.wr_cnt <= count_q.wr_cnt + 1'b1;
            end
        end
    end

    assign count_o = count_q;

endmodule

`default_nettype wire

// File: src/csr_mon_pkg.sv
// ==========================================================================
// memory-monitor CSR shared definitions
// widths, register map, read window constants, FSM enums, bus and
// config structs, plus the byte-enable mask helper
// ==========================================================================
`default_nettype none

package csr_mon_pkg;

    // bus and datapath widths
    localparam int DATA_W = 64;
    localparam int BE_W   = 8;
    localparam int ADDR_W = 32;
    localparam int PFN_W  = 28;
    localparam int CNT_W  = 32;
    // word index is address bits 21:3
    localparam int WIDX_W = 19;

    // ======================================================================
    // register map, word addresses
    // ======================================================================
    localparam int REG_ID          = 0;
    localparam int REG_RD_TOTAL    = 1;
    localparam int REG_WR_TOTAL    = 2;
    localparam int REG_MIG_CNT     = 3;
    localparam int REG_PFN_STATUS  = 4;
    // first read/write word, everything below is status
    localparam int RW_BASE         = 8;
    localparam int REG_QUERY_RATE  = 8;
    localparam int REG_START_PA    = 10;
    localparam int REG_PFN_IDX_RST = 11;
    localparam int REG_AXUSER      = 13;
    localparam int REG_ADDR_OFFSET = 14;
    localparam int REG_ADDR_LB     = 15;
    localparam int REG_ADDR_UB     = 16;

    // hot-PFN read window, in words
    localparam int PFN_WIN_BASE = 4096;
    localparam int PFN_WIN_END  = 8192;

    localparam logic [DATA_W-1:0] ID_VALUE    = 64'hABCD_ABCD_ABCD_ABCD;
    localparam logic [15:0]       PFN_TAG     = 16'h7469;
    localparam logic [31:0]       UNMAPPED_HI = 32'hFEDC_BA00;
    localparam logic [15:0]       UNMAPPED_LO = 16'hABCD;

    typedef enum logic [2:0] {IDLE, WRITE, READ_WAIT, READ_WAIT2, READ} csr_state_e;
    typedef enum logic [1:0] {SRC_REG, SRC_PFN, SRC_UNMAPPED} rd_src_e;

    // slave-port request as seen at the top
    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] writedata;
        logic [BE_W-1:0]   byteenable;
    } csr_req_t;

    // decoded configuration words
    typedef struct packed {
        logic [31:0]       query_rate;
        logic [DATA_W-1:0] start_pa;
        logic [5:0]        aruser;
        logic [5:0]        awuser;
        logic [DATA_W-1:0] addr_offset;
        logic [32:0]       addr_lb;
        logic [32:0]       addr_ub;
    } csr_cfg_t;

    typedef struct packed {
        logic [CNT_W-1:0] rd_cnt;
        logic [CNT_W-1:0] wr_cnt;
    } chan_count_t;

    typedef struct packed {
        logic [9:0]  wr_idx;
        logic [15:0] overflow_cnt;
    } pfn_status_t;

    // one byte lane of ones per set enable bit
    function automatic logic [DATA_W-1:0] byte_mask(input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] m;
        for (int i = 0; i < BE_W; i++) begin
            m[i*8 +: 8] = {8{be[i]}};
        end
        return m;
    endfunction

endpackage

`default_nettype wire
